// File: rtl/board_ctrl_pkg.sv
// shared widths, types and constants; the ICAP words are UltraScale+ bitstream commands
package board_ctrl_pkg;

    // board I/O vectors
    // buttons are ordered up, left, down, right, centre from msb to lsb
    typedef logic [4:0]  btn_t;
    typedef logic [3:0]  sw_t;

    // buttons sit above the switches
    typedef logic [8:0]  gpio_t;

    typedef logic [7:0]  led_t;
    typedef logic [15:0] pcs_status_t;

    // one ICAP configuration word, before the per-byte bit swap
    typedef logic [31:0] icap_word_t;

    typedef enum logic [2:0] {
        REBOOT_IDLE,
        REBOOT_SYNC,
        REBOOT_NOOP,
        REBOOT_CMD,
        REBOOT_IPROG,
        REBOOT_TAIL
    } reboot_state_t;

    // equal samples needed before a debounced bit follows its input
    localparam int unsigned DEBOUNCE_DEPTH = 4;

    // flip-flops on the asynchronous reboot request
    localparam int unsigned SYNC_STAGES = 2;

    // reprogram command stream
    localparam icap_word_t ICAP_DUMMY_WORD     = 32'hFFFFFFFF;
    localparam icap_word_t ICAP_SYNC_WORD      = 32'hAA995566;
    // type 1 packet, no-op
    localparam icap_word_t ICAP_NOOP_WORD      = 32'h20000000;
    // type 1 write of one word to the CMD register
    localparam icap_word_t ICAP_WRITE_CMD_WORD = 32'h30008001;
    localparam icap_word_t ICAP_IPROG_WORD     = 32'h0000000F;

    // LED view selection
    // sw bit 3 off shows the user byte, on shows the PCS status vector
    localparam int unsigned LED_SEL_SW_BIT  = 3;
    // sw bit 0 picks the status half, on for bits 15..8
    localparam int unsigned LED_HALF_SW_BIT = 0;

endpackage

// File: rtl/gpio_debounce.sv
// inputs are sampled straight off the pins once per tick, sample_period must be at least 1
`timescale 1ns/1ps

module gpio_debounce #(
    parameter int unsigned sample_period = 156000
) (
    input  logic                 clk_125mhz_int,
    input  logic                 rst_n_i,
    input  board_ctrl_pkg::gpio_t gpio_i,
    output board_ctrl_pkg::gpio_t gpio_o
);

    import board_ctrl_pkg::*;

    localparam int unsigned GPIO_W = $bits(gpio_t);
    localparam int unsigned CNT_W  = $clog2(sample_period + 1);

    logic [CNT_W-1:0]          tick_cnt_q;
    logic                      sample_tick;
    logic [DEBOUNCE_DEPTH-1:0] sample_q [GPIO_W];

    // sample tick generator
    // counts down and reloads, the tick is the cycle spent at zero
    assign sample_tick = (tick_cnt_q == '0);

    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tick_cnt_q <= '0;
        end else if (sample_tick) begin
            tick_cnt_q <= CNT_W'(sample_period - 1);
        end else begin
            tick_cnt_q <= tick_cnt_q - 1'b1;
        end
    end

    // sample history, newest sample in bit 0
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < GPIO_W; i++) begin
                sample_q[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < GPIO_W; i++) begin
                sample_q[i] <= {sample_q[i][DEBOUNCE_DEPTH-2:0], gpio_i[i]};
            end
        end
    end

    // a bit only moves once the whole history agrees
    // mixed histories hold the last settled value
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_o <= '0;
        end else begin
            for (int i = 0; i < GPIO_W; i++) begin
                if (&sample_q[i]) begin
                    gpio_o[i] <= 1'b1;
                end else if (~|sample_q[i]) begin
                    gpio_o[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/icap_reboot_seq.sv
// write-only ICAP driver, the port has no back-pressure and AVAIL only gates the start
`timescale 1ns/1ps

module icap_reboot_seq (
    input  logic                      clk_125mhz_int,
    input  logic                      rst_n_i,
    input  logic                      reboot_req_i,
    input  logic                      icap_avail_i,
    output logic                      icap_csib_o,
    output board_ctrl_pkg::icap_word_t icap_data_o
);

    import board_ctrl_pkg::*;

    logic [SYNC_STAGES-1:0] req_sync_q;
    logic                   req_sync;

    reboot_state_t state_q;
    logic          csib_q;
    icap_word_t    word_q;

    // request synchronizer
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_sync_q <= '0;
        end else begin
            req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], reboot_req_i};
        end
    end

    assign req_sync = req_sync_q[SYNC_STAGES-1];

    // command FSM
    // each state registers the chip select and the word shown in the next cycle,
    // so csib is low for the six cycles following the start in idle
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= REBOOT_IDLE;
            csib_q  <= 1'b1;
            word_q  <= ICAP_DUMMY_WORD;
        end else begin
            case (state_q)
                REBOOT_IDLE: begin
                    csib_q <= 1'b1;
                    word_q <= ICAP_DUMMY_WORD;
                    // csib_q low here means a sequence just ended
                    // that cycle is spent deselected before a repeat
                    if (req_sync && icap_avail_i && csib_q) begin
                        state_q <= REBOOT_SYNC;
                        csib_q  <= 1'b0;
                    end
                end
                REBOOT_SYNC: begin
                    state_q <= REBOOT_NOOP;
                    csib_q  <= 1'b0;
                    word_q  <= ICAP_SYNC_WORD;
                end
                REBOOT_NOOP: begin
                    state_q <= REBOOT_CMD;
                    csib_q  <= 1'b0;
                    word_q  <= ICAP_NOOP_WORD;
                end
                REBOOT_CMD: begin
                    state_q <= REBOOT_IPROG;
                    csib_q  <= 1'b0;
                    word_q  <= ICAP_WRITE_CMD_WORD;
                end
                REBOOT_IPROG: begin
                    state_q <= REBOOT_TAIL;
                    csib_q  <= 1'b0;
                    word_q  <= ICAP_IPROG_WORD;
                end
                REBOOT_TAIL: begin
                    // trailing no-op flushes the IPROG command
                    state_q <= REBOOT_IDLE;
                    csib_q  <= 1'b0;
                    word_q  <= ICAP_NOOP_WORD;
                end
                default: begin
                    state_q <= REBOOT_IDLE;
                    csib_q  <= 1'b1;
                    word_q  <= ICAP_DUMMY_WORD;
                end
            endcase
        end
    end

    assign icap_csib_o = csib_q;

    // ICAP takes each byte with its bit order swapped
    always_comb begin
        for (int b = 0; b < $bits(icap_word_t) / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                icap_data_o[8*b + 7 - i] = word_q[8*b + i];
            end
        end
    end

endmodule

// File: rtl/board_ctrl_top.sv
// LED view follows the debounced switches, so a switch change shows after the debounce delay
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int unsigned sample_period = 156000
) (
    input  logic                       clk_125mhz_int,
    input  logic                       rst_n_i,

    // buttons and switches
    input  board_ctrl_pkg::btn_t        btn_i,
    input  board_ctrl_pkg::sw_t         sw_i,
    output board_ctrl_pkg::btn_t        btn_o,
    output board_ctrl_pkg::sw_t         sw_o,

    // LEDs
    input  board_ctrl_pkg::led_t        user_led_i,
    input  board_ctrl_pkg::pcs_status_t pcs_status_i,
    output board_ctrl_pkg::led_t        led_o,

    // reboot through the configuration port
    input  logic                       reboot_req_i,
    input  logic                       icap_avail_i,
    output logic                       icap_csib_o,
    output board_ctrl_pkg::icap_word_t  icap_data_o
);

    import board_ctrl_pkg::*;

    gpio_t gpio_raw;
    gpio_t gpio_db;

    // buttons above switches, matching gpio_t
    assign gpio_raw = {btn_i, sw_i};

    gpio_debounce #(
        .sample_period(sample_period)
    ) gpio_debounce_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .gpio_i        (gpio_raw),
        .gpio_o        (gpio_db)
    );

    assign {btn_o, sw_o} = gpio_db;

    // status view select
    always_comb begin
        if (!sw_o[LED_SEL_SW_BIT]) begin
            led_o = user_led_i;
        end else if (sw_o[LED_HALF_SW_BIT]) begin
            led_o = pcs_status_i[15:8];
        end else begin
            led_o = pcs_status_i[7:0];
        end
    end

    icap_reboot_seq icap_reboot_seq_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .reboot_req_i  (reboot_req_i),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_data_o   (icap_data_o)
    );

endmodule

// File: verification/icap_reboot_seq_chk.sv
// watches only the ICAP side and the FSM state; the request synchronizer is not observed
`timescale 1ns/1ps

module icap_reboot_seq_chk (
    input logic                          clk_125mhz_int,
    input logic                          rst_n_i,
    input logic                          icap_csib_i,
    input board_ctrl_pkg::icap_word_t    icap_data_i,
    input board_ctrl_pkg::reboot_state_t state_i
);

    import board_ctrl_pkg::*;

    localparam logic [3:0] MAX_LOW_CYCLES = 4'd6;

    logic [3:0] low_run_q;

    // consecutive cycles with the port selected, saturating
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            low_run_q <= '0;
        end else if (icap_csib_i) begin
            low_run_q <= '0;
        end else if (low_run_q != 4'hF) begin
            low_run_q <= low_run_q + 1'b1;
        end
    end

    csib_low_max: assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        low_run_q <= MAX_LOW_CYCLES)
        else $error("icap_csib low for more than six cycles");

    // all ones stays all ones after the per-byte swap
    idle_data_dummy: assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        icap_csib_i |-> (icap_data_i == 32'hFFFF_FFFF))
        else $error("icap data is not the dummy word while deselected");

    state_legal: assert property (@(posedge clk_125mhz_int) disable iff (!rst_n_i)
        state_i inside {REBOOT_IDLE, REBOOT_SYNC, REBOOT_NOOP,
                        REBOOT_CMD, REBOOT_IPROG, REBOOT_TAIL})
        else $error("reboot FSM state outside its encoding");

endmodule

bind icap_reboot_seq icap_reboot_seq_chk icap_reboot_seq_chk_i (
    .clk_125mhz_int(clk_125mhz_int),
    .rst_n_i       (rst_n_i),
    .icap_csib_i   (icap_csib_o),
    .icap_data_i   (icap_data_o),
    .state_i       (state_q)
);

// File: verification/board_ctrl_tb.sv
// built for sample_period 8; debounce waits scale with DEBOUNCE_DEPTH from the package
`timescale 1ns/1ps

module board_ctrl_tb;

    import board_ctrl_pkg::*;

    localparam int CLK_PERIOD       = 8;
    localparam int SAMPLE_PERIOD    = 8;
    localparam int SETTLE_CYCLES    = (int'(DEBOUNCE_DEPTH) + 1) * SAMPLE_PERIOD + 2;
    localparam int GLITCH_CYCLES    = 5;
    localparam int DEBOUNCE_ROUNDS  = 4;
    localparam int REQ_PULSE_CYCLES = 3;
    localparam int START_LIMIT      = int'(SYNC_STAGES) + 2;
    localparam int IDLE_HOLD_CYCLES = 20;
    localparam int GATE_CYCLES      = 40;

    // worst case per test, in clock cycles
    localparam int RESET_WC    = 4;
    localparam int DEBOUNCE_WC = DEBOUNCE_ROUNDS * (SETTLE_CYCLES + 2)
                                 + GLITCH_CYCLES + SETTLE_CYCLES + 2;
    localparam int LED_WC      = 4 * (SETTLE_CYCLES + 4);
    localparam int REBOOT_WC   = 2 + START_LIMIT + 6 + IDLE_HOLD_CYCLES;
    localparam int GATE_WC     = 2 + GATE_CYCLES + START_LIMIT + 6 + IDLE_HOLD_CYCLES;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_WC + DEBOUNCE_WC + LED_WC + REBOOT_WC + GATE_WC);

    logic        clk_125mhz_int;
    logic        rst_n_i;
    btn_t        btn_i;
    sw_t         sw_i;
    btn_t        btn_o;
    sw_t         sw_o;
    led_t        user_led_i;
    pcs_status_t pcs_status_i;
    led_t        led_o;
    logic        reboot_req_i;
    logic        icap_avail_i;
    logic        icap_csib_o;
    icap_word_t  icap_data_o;

    integer seed;
    int     error_count = 0;
    int     test_count = 0;
    int     failed_count = 0;

    board_ctrl_top #(
        .sample_period(SAMPLE_PERIOD)
    ) dut_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .btn_i         (btn_i),
        .sw_i          (sw_i),
        .btn_o         (btn_o),
        .sw_o          (sw_o),
        .user_led_i    (user_led_i),
        .pcs_status_i  (pcs_status_i),
        .led_o         (led_o),
        .reboot_req_i  (reboot_req_i),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_data_o   (icap_data_o)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125mhz_int = ~clk_125mhz_int;
    end

    // reprogram stream in send order, before the bit swap
    function automatic logic [31:0] command_word(input int idx);
        case (idx)
            0: return 32'hFFFF_FFFF;
            1: return 32'hAA99_5566;
            2: return 32'h2000_0000;
            3: return 32'h3000_8001;
            4: return 32'h0000_000F;
            default: return 32'h2000_0000;
        endcase
    endfunction

    function automatic logic [31:0] swap_bits_per_byte(input logic [31:0] word);
        logic [31:0] swapped;
        for (int b = 0; b < 4; b++) begin
            swapped[8*b +: 8] = {<<{word[8*b +: 8]}};
        end
        return swapped;
    endfunction

    function automatic led_t expected_led(input sw_t sw, input led_t user_led,
                                          input pcs_status_t status);
        if (!sw[LED_SEL_SW_BIT]) begin
            return user_led;
        end
        if (sw[LED_HALF_SW_BIT]) begin
            return status[15:8];
        end
        return status[7:0];
    endfunction

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
        error_count++;
    endtask

    task automatic finish_test(input string test_name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_count++;
            $display("test %s: FAILED with %0d errors", test_name,
                     error_count - errors_before);
        end
    endtask

    // returns at the negedge where csib is first seen low
    task automatic wait_for_select(input string test_name, output bit seen);
        int lat;
        lat = 0;
        seen = 1'b0;
        while (!seen && lat < START_LIMIT) begin
            @(negedge clk_125mhz_int);
            lat++;
            if (icap_csib_o == 1'b0) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("ERROR %s: icap_csib_o did not go low within %0d cycles",
                     test_name, START_LIMIT);
            error_count++;
        end
    endtask

    task automatic check_command_stream(input string test_name);
        logic [31:0] exp_word;
        for (int k = 0; k < 6; k++) begin
            if (k > 0) begin
                @(negedge clk_125mhz_int);
            end
            exp_word = swap_bits_per_byte(command_word(k));
            if (icap_csib_o != 1'b0) begin
                report_mismatch(test_name, $sformatf("csib at word %0d", k),
                                32'd0, 32'(icap_csib_o));
            end
            if (icap_data_o != exp_word) begin
                report_mismatch(test_name, $sformatf("data word %0d", k),
                                exp_word, icap_data_o);
            end
        end
        for (int c = 0; c < IDLE_HOLD_CYCLES; c++) begin
            @(negedge clk_125mhz_int);
            if (icap_csib_o != 1'b1) begin
                report_mismatch(test_name, $sformatf("csib %0d cycles after stream", c + 1),
                                32'd1, 32'(icap_csib_o));
            end
            if (icap_data_o != 32'hFFFF_FFFF) begin
                report_mismatch(test_name, "idle data", 32'hFFFF_FFFF, icap_data_o);
            end
        end
    endtask

    task automatic reset_test();
        int errs;
        errs = error_count;
        @(negedge clk_125mhz_int);
        if (btn_o != '0) begin
            report_mismatch("reset", "btn_o", 32'd0, 32'(btn_o));
        end
        if (sw_o != '0) begin
            report_mismatch("reset", "sw_o", 32'd0, 32'(sw_o));
        end
        if (icap_csib_o != 1'b1) begin
            report_mismatch("reset", "icap_csib_o", 32'd1, 32'(icap_csib_o));
        end
        if (icap_data_o != 32'hFFFF_FFFF) begin
            report_mismatch("reset", "icap_data_o", 32'hFFFF_FFFF, icap_data_o);
        end
        if (led_o != user_led_i) begin
            report_mismatch("reset", "led_o", 32'(user_led_i), 32'(led_o));
        end
        finish_test("reset", errs);
    endtask

    task automatic debounce_test();
        int   errs;
        btn_t btn_val;
        sw_t  sw_val;
        bit   glitch_seen;
        errs = error_count;
        btn_val = '0;
        sw_val = '0;
        for (int r = 0; r < DEBOUNCE_ROUNDS; r++) begin
            @(posedge clk_125mhz_int);
            btn_val = btn_t'($random(seed));
            sw_val = sw_t'($random(seed));
            btn_i <= btn_val;
            sw_i <= sw_val;
            repeat (SETTLE_CYCLES) @(posedge clk_125mhz_int);
            @(negedge clk_125mhz_int);
            if (btn_o != btn_val) begin
                report_mismatch("debounce", "btn_o", 32'(btn_val), 32'(btn_o));
            end
            if (sw_o != sw_val) begin
                report_mismatch("debounce", "sw_o", 32'(sw_val), 32'(sw_o));
            end
        end
        // inverted pulse shorter than one sample period
        glitch_seen = 1'b0;
        @(posedge clk_125mhz_int);
        btn_i <= ~btn_val;
        sw_i <= ~sw_val;
        for (int c = 1; c <= GLITCH_CYCLES + SETTLE_CYCLES; c++) begin
            @(negedge clk_125mhz_int);
            if (!glitch_seen && (btn_o != btn_val || sw_o != sw_val)) begin
                glitch_seen = 1'b1;
                report_mismatch("debounce", "outputs after short pulse",
                                32'({btn_val, sw_val}), 32'({btn_o, sw_o}));
            end
            @(posedge clk_125mhz_int);
            if (c == GLITCH_CYCLES) begin
                btn_i <= btn_val;
                sw_i <= sw_val;
            end
        end
        finish_test("debounce", errs);
    endtask

    task automatic led_select_test();
        int          errs;
        sw_t         sw_val;
        sw_t         prev_sw;
        led_t        led_val;
        pcs_status_t status_val;
        led_t        exp_led;
        errs = error_count;
        prev_sw = sw_i;
        for (int combo = 0; combo < 4; combo++) begin
            @(posedge clk_125mhz_int);
            sw_val = sw_t'($random(seed));
            sw_val[LED_SEL_SW_BIT] = combo[1];
            sw_val[LED_HALF_SW_BIT] = combo[0];
            led_val = led_t'($random(seed));
            status_val = pcs_status_t'($random(seed));
            sw_i <= sw_val;
            user_led_i <= led_val;
            pcs_status_i <= status_val;
            // old switch setting holds until the debounce completes
            @(negedge clk_125mhz_int);
            exp_led = expected_led(prev_sw, led_val, status_val);
            if (led_o != exp_led) begin
                report_mismatch("led_select", $sformatf("led_o before debounce combo %0d", combo),
                                32'(exp_led), 32'(led_o));
            end
            repeat (SETTLE_CYCLES) @(posedge clk_125mhz_int);
            @(negedge clk_125mhz_int);
            exp_led = expected_led(sw_val, led_val, status_val);
            if (led_o != exp_led) begin
                report_mismatch("led_select", $sformatf("led_o combo %0d", combo),
                                32'(exp_led), 32'(led_o));
            end
            // the select is combinational, new data shows at once
            @(posedge clk_125mhz_int);
            led_val = led_t'($random(seed));
            status_val = pcs_status_t'($random(seed));
            user_led_i <= led_val;
            pcs_status_i <= status_val;
            @(negedge clk_125mhz_int);
            exp_led = expected_led(sw_val, led_val, status_val);
            if (led_o != exp_led) begin
                report_mismatch("led_select", $sformatf("led_o update combo %0d", combo),
                                32'(exp_led), 32'(led_o));
            end
            prev_sw = sw_val;
        end
        finish_test("led_select", errs);
    endtask

    task automatic reboot_sequence_test();
        int errs;
        bit seen;
        errs = error_count;
        @(posedge clk_125mhz_int);
        icap_avail_i <= 1'b1;
        @(posedge clk_125mhz_int);
        reboot_req_i <= 1'b1;
        fork
            begin
                repeat (REQ_PULSE_CYCLES) @(posedge clk_125mhz_int);
                reboot_req_i <= 1'b0;
            end
        join_none
        wait_for_select("reboot", seen);
        if (seen) begin
            check_command_stream("reboot");
        end
        finish_test("reboot", errs);
    endtask

    task automatic start_gating_test();
        int errs;
        bit seen;
        bit early;
        errs = error_count;
        early = 1'b0;
        @(posedge clk_125mhz_int);
        icap_avail_i <= 1'b0;
        reboot_req_i <= 1'b1;
        for (int c = 0; c < GATE_CYCLES; c++) begin
            @(negedge clk_125mhz_int);
            if (!early && icap_csib_o != 1'b1) begin
                early = 1'b1;
                report_mismatch("start_gating", "csib with icap_avail_i low",
                                32'd1, 32'(icap_csib_o));
            end
        end
        @(posedge clk_125mhz_int);
        icap_avail_i <= 1'b1;
        wait_for_select("start_gating", seen);
        if (seen) begin
            // drop the request before the sequence ends so it does not repeat
            fork
                begin
                    @(posedge clk_125mhz_int);
                    reboot_req_i <= 1'b0;
                end
            join_none
            check_command_stream("start_gating");
        end
        finish_test("start_gating", errs);
    endtask

    initial begin
        seed = 32'h3bb46155;
        rst_n_i = 1'b0;
        btn_i = '0;
        sw_i = '0;
        user_led_i = led_t'($random(seed));
        pcs_status_i = pcs_status_t'($random(seed));
        reboot_req_i = 1'b0;
        icap_avail_i = 1'b0;
        repeat (2) @(posedge clk_125mhz_int);
        rst_n_i <= 1'b1;

        reset_test();
        debounce_test();
        led_select_test();
        reboot_sequence_test();
        start_gating_test();

        $display("tests run: %0d, failed: %0d, errors: %0d",
                 test_count, failed_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: board_ctrl.f
rtl/board_ctrl_pkg.sv
rtl/gpio_debounce.sv
rtl/icap_reboot_seq.sv
rtl/board_ctrl_top.sv
verification/icap_reboot_seq_chk.sv
verification/board_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module board_ctrl_tb \
    -f board_ctrl.f \
    --Mdir obj_dir \
    -o board_ctrl_sim

status=0
output=$(./obj_dir/board_ctrl_sim 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
fi
exit 1
